/* Bender.yml */
package:
  name: mem_l2

export_include_dirs:
  - .

sources:
  - memL2Pkg.sv
  - memL2Decode.sv
  - memL2Rom.sv
  - memL2DdrPort.sv
  - memL2Resp.sv
  - memL2A.sv
  - target: test
    files:
      - tbMemL2A.sv

/* memL2A.sv */
`include "memL2_defines.svh"

module memL2A
	import memL2Pkg::*;
(
	input logic clock,
	input logic rstN,
	input logic [`MEM_ADDR_W-1:0] memAddr,
	input logic [`MEM_LINE_W-1:0] memDataIn,
	input memOpmU memOpm,
	output logic [`MEM_LINE_W-1:0] memDataOut,
	output memOkE memOK,
	output logic [`MEM_ADDR_W-1:0] ddrMemAddr,
	output memOpmE ddrMemOpm,
	input logic [`MEM_LINE_W-1:0] ddrMemDataIn,
	output logic [`MEM_LINE_W-1:0] ddrMemDataOut,
	input memOkE ddrMemOK,
	output logic [`MEM_ADDR_W-1:0] mmioAddr,
	output memOpmE mmioOpm,
	input logic [`MEM_MMIO_W-1:0] mmioInData,
	output logic [`MEM_MMIO_W-1:0] mmioOutData,
	input memOkE mmioOK
);

	memReqKindE reqKind;
	memOpmE romOpm;
	memOpmE ddrOpm;
	memOpmE mmioReqOpm;
	logic [`MEM_LINE_W-1:0] romData;
	memOkE romOK;
	logic [`MEM_LINE_W-1:0] ddrData;
	memOkE ddrOK;

	memL2Decode i_decode (
		.memOpm (memOpm),
		.memAddr (memAddr),
		.reqKind (reqKind),
		.romOpm (romOpm),
		.ddrOpm (ddrOpm),
		.mmioOpm (mmioReqOpm)
	);

	memL2Rom i_rom (
		.clock (clock),
		.rstN (rstN),
		.memAddr (memAddr),
		.romOpm (romOpm),
		.romData (romData),
		.romOK (romOK)
	);

	memL2DdrPort i_ddrPort (
		.clock (clock),
		.rstN (rstN),
		.memAddr (memAddr),
		.memDataIn (memDataIn),
		.ddrOpm (ddrOpm),
		.ddrMemDataIn (ddrMemDataIn),
		.ddrMemOK (ddrMemOK),
		.ddrMemAddr (ddrMemAddr),
		.ddrMemOpm (ddrMemOpm),
		.ddrMemDataOut (ddrMemDataOut),
		.ddrData (ddrData),
		.ddrOK (ddrOK)
	);

	memL2Resp i_resp (
		.clock (clock),
		.rstN (rstN),
		.memOpm (memOpm),
		.memDataIn (memDataIn),
		.memAddr (memAddr),
		.reqKind (reqKind),
		.mmioOpmIn (mmioReqOpm),
		.romData (romData),
		.romOK (romOK),
		.ddrData (ddrData),
		.ddrOK (ddrOK),
		.mmioInData (mmioInData),
		.mmioOK (mmioOK),
		.memDataOut (memDataOut),
		.memOK (memOK),
		.mmioAddr (mmioAddr),
		.mmioOpm (mmioOpm),
		.mmioOutData (mmioOutData)
	);

endmodule

/* memL2DdrPort.sv */
`include "memL2_defines.svh"

module memL2DdrPort
	import memL2Pkg::*;
(
	input logic clock,
	input logic rstN,
	input logic [`MEM_ADDR_W-1:0] memAddr,
	input logic [`MEM_LINE_W-1:0] memDataIn,
	input memOpmE ddrOpm,
	input logic [`MEM_LINE_W-1:0] ddrMemDataIn,
	input memOkE ddrMemOK,
	output logic [`MEM_ADDR_W-1:0] ddrMemAddr,
	output memOpmE ddrMemOpm,
	output logic [`MEM_LINE_W-1:0] ddrMemDataOut,
	output logic [`MEM_LINE_W-1:0] ddrData,
	output memOkE ddrOK
);

	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stIssue = 2'd1;
	localparam logic [1:0] stDone = 2'd2;

	logic [1:0] state;
	memOkE ddrOkR;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			ddrOkR <= OK_READY;
			ddrMemOpm <= OPM_READY;
			ddrMemAddr <= '0;
			ddrMemDataOut <= '0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					// wait for the port to finish its previous answer too
					if ((ddrOpm != OPM_READY) && (ddrMemOK == OK_READY))
					begin
						ddrMemOpm <= ddrOpm;
						ddrMemAddr <= memAddr;
						ddrMemDataOut <= memDataIn;
						state <= stIssue;
					end
				end
				stIssue:
				begin
					if ((ddrMemOK == OK_OK) || (ddrMemOK == OK_FAULT))
					begin
						ddrMemOpm <= OPM_READY;
						ddrOkR <= ddrMemOK;
						state <= stDone;
					end
				end
				default:
				begin
					// stay here until the requester lets go
					if (ddrOpm == OPM_READY)
					begin
						ddrOkR <= OK_READY;
						state <= stIdle;
					end
				end
			endcase
		end
	end

	// reply line, captured with the port's answer
	always_ff @(posedge clock)
	begin
		if ((state == stIssue) && (ddrMemOK == OK_OK))
			ddrData <= ddrMemDataIn;
	end

	assign ddrOK = (ddrOpm == OPM_READY) ? OK_READY :
		(state == stDone) ? ddrOkR : OK_HOLD;

endmodule

/* memL2Decode.sv */
`include "memL2_defines.svh"

module memL2Decode
	import memL2Pkg::*;
(
	input memOpmU memOpm,
	input logic [`MEM_ADDR_W-1:0] memAddr,
	output memReqKindE reqKind,
	output memOpmE romOpm,
	output memOpmE ddrOpm,
	output memOpmE mmioOpm
);

	logic isCmd;
	logic isLine;
	logic romHit;

	// command codes only live under kind 00
	assign isCmd = (memOpm.ctl.zero == `MEM_KIND_CMD);
	assign isLine = (memOpm.acc.size == `MEM_SIZE_LINE);

	// lines below 64 KiB come from the boot ROM
	assign romHit = (memAddr[`MEM_ADDR_W-1 -: `MEM_ROM_HI_BITS] == '0);

	always_comb
	begin
		reqKind = REQ_CMD;
		romOpm = OPM_READY;
		ddrOpm = OPM_READY;
		mmioOpm = OPM_READY;

		if (!isCmd)
		begin
			if (!isLine)
			begin
				// sized access, goes out on the 64-bit port
				reqKind = REQ_MMIO;
				mmioOpm = memOpmE'(memOpm);
			end
			else if (romHit)
			begin
				reqKind = REQ_ROM;
				romOpm = memOpmE'(memOpm);
			end
			else
			begin
				reqKind = REQ_DDR;
				ddrOpm = memOpmE'(memOpm);
			end
		end
	end

endmodule

/* memL2Pkg.sv */
package memL2Pkg;

	// request operation codes, kind in [4:3] and size or command in [2:0]
	typedef enum logic [4:0]
	{
		OPM_READY = 5'b00000,
		OPM_LDTLB = 5'b00001,
		OPM_INVTLB = 5'b00010,
		OPM_FLUSHIS = 5'b00011,
		OPM_FLUSHDS = 5'b00100,
		OPM_LDB = 5'b01000,
		OPM_LDW = 5'b01001,
		OPM_LDL = 5'b01010,
		OPM_LDQ = 5'b01011,
		OPM_LDX = 5'b01111,
		OPM_STB = 5'b10000,
		OPM_STW = 5'b10001,
		OPM_STL = 5'b10010,
		OPM_STQ = 5'b10011,
		OPM_STX = 5'b10111,
		OPM_SWQ = 5'b11011,
		OPM_SWX = 5'b11111
	} memOpmE;

	typedef enum logic [1:0]
	{
		OK_READY = 2'd0,
		OK_OK = 2'd1,
		OK_HOLD = 2'd2,
		OK_FAULT = 2'd3
	} memOkE;

	// where a request is routed
	typedef enum logic [1:0]
	{
		REQ_CMD = 2'd0,
		REQ_ROM = 2'd1,
		REQ_DDR = 2'd2,
		REQ_MMIO = 2'd3
	} memReqKindE;

	typedef struct packed
	{
		logic [1:0] kind;
		logic [2:0] size;
	} memOpmAccS;

	typedef struct packed
	{
		logic [1:0] zero;
		logic [2:0] code;
	} memOpmCtlS;

	// same opm word seen as an access or as a cache command
	typedef union packed
	{
		memOpmAccS acc;
		memOpmCtlS ctl;
	} memOpmU;

endpackage

/* memL2Resp.sv */
`include "memL2_defines.svh"

module memL2Resp
	import memL2Pkg::*;
(
	input logic clock,
	input logic rstN,
	input memOpmU memOpm,
	input logic [`MEM_LINE_W-1:0] memDataIn,
	input logic [`MEM_ADDR_W-1:0] memAddr,
	input memReqKindE reqKind,
	input memOpmE mmioOpmIn,
	input logic [`MEM_LINE_W-1:0] romData,
	input memOkE romOK,
	input logic [`MEM_LINE_W-1:0] ddrData,
	input memOkE ddrOK,
	input logic [`MEM_MMIO_W-1:0] mmioInData,
	input memOkE mmioOK,
	output logic [`MEM_LINE_W-1:0] memDataOut,
	output memOkE memOK,
	output logic [`MEM_ADDR_W-1:0] mmioAddr,
	output memOpmE mmioOpm,
	output logic [`MEM_MMIO_W-1:0] mmioOutData
);

	memOkE cmdOK;
	logic mmioLatch;
	logic mmioSel;

	// TLB and flush commands are only acknowledged
	always_comb
	begin
		if (memOpm.ctl.code == 3'd0)
			cmdOK = OK_READY;
		else if (memOpmE'(memOpm) inside {OPM_LDTLB, OPM_INVTLB, OPM_FLUSHIS, OPM_FLUSHDS})
			cmdOK = OK_OK;
		else
			cmdOK = OK_FAULT;
	end

	// keep following the MMIO port until it drops back to READY
	assign mmioSel = (reqKind == REQ_MMIO) || mmioLatch;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			memDataOut <= '0;
			memOK <= OK_READY;
			mmioLatch <= 1'b0;
			mmioAddr <= '0;
			mmioOpm <= OPM_READY;
			mmioOutData <= '0;
		end
		else
		begin
			if (mmioSel)
			begin
				memDataOut <= {{(`MEM_LINE_W-`MEM_MMIO_W){1'b0}}, mmioInData};
				memOK <= mmioOK;
				mmioLatch <= (reqKind == REQ_MMIO) || (mmioOK != OK_READY);
			end
			else
			begin
				case (reqKind)
					REQ_ROM:
					begin
						memDataOut <= romData;
						memOK <= romOK;
					end
					REQ_DDR:
					begin
						memDataOut <= ddrData;
						memOK <= ddrOK;
					end
					default:
					begin
						memDataOut <= '0;
						memOK <= cmdOK;
					end
				endcase
			end

			// MMIO request follows the requester one edge later
			mmioOpm <= mmioOpmIn;
			mmioAddr <= memAddr;
			mmioOutData <= memDataIn[`MEM_MMIO_W-1:0];
		end
	end

endmodule

/* memL2Rom.sv */
`include "memL2_defines.svh"

module memL2Rom
	import memL2Pkg::*;
(
	input logic clock,
	input logic rstN,
	input logic [`MEM_ADDR_W-1:0] memAddr,
	input memOpmE romOpm,
	output logic [`MEM_LINE_W-1:0] romData,
	output memOkE romOK
);

	localparam int romIdxW = $clog2(`MEM_ROM_LINES);

	logic [`MEM_LINE_W-1:0] romMem [0:`MEM_ROM_LINES-1];
	memOkE romOkR;
	logic isLoad;

	initial
	begin
		$readmemh("romImage.hex", romMem);
	end

	assign isLoad = (romOpm[4:3] == `MEM_KIND_LOAD);

	// synchronous line read
	always_ff @(posedge clock)
	begin
		if (isLoad)
			romData <= romMem[memAddr[romIdxW+3:4]];
	end

	// answer decided on the first edge, stores and swaps are refused
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			romOkR <= OK_READY;
		else if (romOpm == OPM_READY)
			romOkR <= OK_READY;
		else if (isLoad)
			romOkR <= OK_OK;
		else
			romOkR <= OK_FAULT;
	end

	// hold until the read has happened
	assign romOK = (romOpm == OPM_READY) ? OK_READY :
		(romOkR == OK_READY) ? OK_HOLD : romOkR;

endmodule

/* memL2_defines.svh */
`ifndef MEM_L2_DEFINES_SVH
`define MEM_L2_DEFINES_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_LINE_W 128
`define MEM_MMIO_W 64

// boot ROM window, upper address bits that must be zero
`define MEM_ROM_HI_BITS 16

// 64 KiB of 16-byte lines
`define MEM_ROM_LINES 4096

// fields of the opm word
`define MEM_KIND_CMD 2'b00
`define MEM_KIND_LOAD 2'b01
`define MEM_SIZE_LINE 3'b111

`endif

/* romImage.hex */
// one 128-bit ROM line per row, row n holds the line at byte address n*16
// words from high to low: b00700nn, nn repeated, 5a5a5a5a, ~nn
b00700000000000005a5a5a5affffffff
b0070001010101015a5a5a5afffffffe
b0070002020202025a5a5a5afffffffd
b0070003030303035a5a5a5afffffffc
b0070004040404045a5a5a5afffffffb
b0070005050505055a5a5a5afffffffa
b0070006060606065a5a5a5afffffff9
b0070007070707075a5a5a5afffffff8
b0070008080808085a5a5a5afffffff7
b0070009090909095a5a5a5afffffff6
b007000a0a0a0a0a5a5a5a5afffffff5
b007000b0b0b0b0b5a5a5a5afffffff4
b007000c0c0c0c0c5a5a5a5afffffff3
b007000d0d0d0d0d5a5a5a5afffffff2
b007000e0e0e0e0e5a5a5a5afffffff1
b007000f0f0f0f0f5a5a5a5afffffff0

/* sources.f */
+incdir+.
memL2Pkg.sv
memL2Decode.sv
memL2Rom.sv
memL2DdrPort.sv
memL2Resp.sv
memL2A.sv
tbMemL2A.sv

/* tbMemL2A.sv */
`include "memL2_defines.svh"

module tbMemL2A
	import memL2Pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct
	{
		string name;
		logic [4:0] opm;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_LINE_W-1:0] wdata;
		logic [`MEM_LINE_W-1:0] expData;
		memOkE expOk;
		int lat;
	} tableEntryT;

	localparam logic [`MEM_LINE_W-1:0] lineA = 128'h0123456789abcdef_fedcba9876543210;
	localparam logic [`MEM_LINE_W-1:0] lineB = 128'hcafef00d_11223344_55667788_99aabbcc;
	localparam logic [`MEM_LINE_W-1:0] lineC = 128'h0f0f0f0f_f0f0f0f0_a5a5a5a5_3c3c3c3c;
	localparam logic [`MEM_LINE_W-1:0] mmioA = 128'hffff0000_11112222_01234567_89abcdef;
	localparam logic [`MEM_LINE_W-1:0] mmioB = 128'h55555555_aaaaaaaa_fedcba98_76543210;

	logic clock;
	logic rstN;
	logic [`MEM_ADDR_W-1:0] memAddr;
	logic [`MEM_LINE_W-1:0] memDataIn;
	logic [4:0] memOpm;
	logic [`MEM_LINE_W-1:0] memDataOut;
	memOkE memOK;
	logic [`MEM_ADDR_W-1:0] ddrMemAddr;
	memOpmE ddrMemOpm;
	logic [`MEM_LINE_W-1:0] ddrMemDataIn;
	logic [`MEM_LINE_W-1:0] ddrMemDataOut;
	memOkE ddrMemOK;
	logic [`MEM_ADDR_W-1:0] mmioAddr;
	memOpmE mmioOpm;
	logic [`MEM_MMIO_W-1:0] mmioInData;
	logic [`MEM_MMIO_W-1:0] mmioOutData;
	memOkE mmioOK;

	tableEntryT tests[$];
	logic [`MEM_LINE_W-1:0] romRef [0:15];
	logic [`MEM_LINE_W-1:0] ddrLines [logic [27:0]];
	logic [`MEM_MMIO_W-1:0] mmioRegs [0:31];
	logic [31:0] lcgState = 32'h79e5;
	string curName = "reset";
	bit tableReady = 1'b0;
	int ddrIssued = 0;
	int errors = 0;
	int checks = 0;

	memL2A i_dut (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	function automatic int nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return int'(lcgState[31:16]);
	endfunction

	function automatic void pushEntry(input string name, input logic [4:0] opm,
		input logic [`MEM_ADDR_W-1:0] addr, input logic [`MEM_LINE_W-1:0] wdata,
		input logic [`MEM_LINE_W-1:0] expData, input memOkE expOk, input int lat);
		tableEntryT t;
		t.name = name;
		t.opm = opm;
		t.addr = addr;
		t.wdata = wdata;
		t.expData = expData;
		t.expOk = expOk;
		t.lat = lat;
		tests.push_back(t);
	endfunction

	// commands answer on edge 1 and ROM lines on edge 2 while port latency varies
	function automatic void buildTable();
		pushEntry("ldtlb", OPM_LDTLB, 32'h0, '0, '0, OK_OK, 1);
		pushEntry("invtlb", OPM_INVTLB, 32'h0, '0, '0, OK_OK, 1);
		pushEntry("flushis", OPM_FLUSHIS, 32'h0, '0, '0, OK_OK, 1);
		pushEntry("flushds", OPM_FLUSHDS, 32'h0, '0, '0, OK_OK, 1);
		pushEntry("cmd5", 5'b00101, 32'h0, '0, '0, OK_FAULT, 1);
		pushEntry("cmd7", 5'b00111, 32'h0, '0, '0, OK_FAULT, 1);
		pushEntry("romLine0", OPM_LDX, 32'h0000_0000, '0, romRef[0], OK_OK, 2);
		pushEntry("romLine5", OPM_LDX, 32'h0000_0050, '0, romRef[5], OK_OK, 2);
		pushEntry("romLine10", OPM_LDX, 32'h0000_00a8, '0, romRef[10], OK_OK, 2);
		pushEntry("romLine15", OPM_LDX, 32'h0000_00f0, '0, romRef[15], OK_OK, 2);
		pushEntry("romStore", OPM_STX, 32'h0000_0020, lineA, '0, OK_FAULT, 2);
		pushEntry("romSwap", OPM_SWX, 32'h0000_0030, lineB, '0, OK_FAULT, 2);
		pushEntry("ddrStA", OPM_STX, 32'h8000_0000, lineA, '0, OK_OK, 0);
		// first line above the ROM window
		pushEntry("ddrStB", OPM_STX, 32'h0001_0000, lineB, '0, OK_OK, 0);
		pushEntry("ddrLdA", OPM_LDX, 32'h8000_0000, '0, lineA, OK_OK, 0);
		pushEntry("ddrStC", OPM_STX, 32'h8000_1230, lineC, '0, OK_OK, 0);
		pushEntry("ddrLdB", OPM_LDX, 32'h0001_0000, '0, lineB, OK_OK, 0);
		pushEntry("ddrLdC", OPM_LDX, 32'h8000_1230, '0, lineC, OK_OK, 0);
		pushEntry("mmioSt2", OPM_STQ, 32'h4000_0010, mmioA, '0, OK_OK, 0);
		pushEntry("mmioSt9", OPM_STQ, 32'h4000_0048, mmioB, '0, OK_OK, 0);
		pushEntry("mmioLd2", OPM_LDQ, 32'h4000_0010, '0, {64'h0, mmioA[63:0]}, OK_OK, 0);
		pushEntry("mmioLd9", OPM_LDQ, 32'h4000_0048, '0, {64'h0, mmioB[63:0]}, OK_OK, 0);
	endfunction

	// DDR model with a sparse line store and zero data on store replies
	initial
	begin
		int holdCycles;
		ddrMemOK = OK_READY;
		ddrMemDataIn = '0;
		forever
		begin
			@(posedge clock);
			if (ddrMemOpm != OPM_READY)
			begin
				ddrIssued++;
				holdCycles = nextRand() % 4;
				repeat (holdCycles)
				begin
					ddrMemOK <= OK_HOLD;
					@(posedge clock);
				end
				if (ddrMemOpm[4:3] == 2'b10)
				begin
					ddrLines[ddrMemAddr[31:4]] = ddrMemDataOut;
					ddrMemDataIn <= '0;
				end
				else if (ddrLines.exists(ddrMemAddr[31:4]))
					ddrMemDataIn <= ddrLines[ddrMemAddr[31:4]];
				else
					ddrMemDataIn <= '0;
				ddrMemOK <= OK_OK;
				@(posedge clock);
				while (ddrMemOpm != OPM_READY)
					@(posedge clock);
				ddrMemOK <= OK_READY;
			end
		end
	end

	// MMIO model with 32 registers of 64 bits
	initial
	begin
		int holdCycles;
		mmioOK = OK_READY;
		mmioInData = '0;
		forever
		begin
			@(posedge clock);
			if (mmioOpm != OPM_READY)
			begin
				holdCycles = nextRand() % 4;
				repeat (holdCycles)
				begin
					mmioOK <= OK_HOLD;
					@(posedge clock);
				end
				if (mmioOpm[4:3] == 2'b10)
				begin
					mmioRegs[mmioAddr[7:3]] = mmioOutData;
					mmioInData <= '0;
				end
				else
					mmioInData <= mmioRegs[mmioAddr[7:3]];
				mmioOK <= OK_OK;
				@(posedge clock);
				while (mmioOpm != OPM_READY)
					@(posedge clock);
				mmioOK <= OK_READY;
			end
		end
	end

	task automatic checkIdle();
		int errorsBefore;
		errorsBefore = errors;
		@(negedge clock);
		checks++;
		assert (memOK == OK_READY)
		else
		begin
			$display("FAILED reset: expected memOK %0d actual %0d", OK_READY, memOK);
			errors++;
		end
		checks++;
		assert (ddrMemOpm == OPM_READY)
		else
		begin
			$display("FAILED reset: expected ddrMemOpm %0d actual %0d",
				OPM_READY, ddrMemOpm);
			errors++;
		end
		checks++;
		assert (mmioOpm == OPM_READY)
		else
		begin
			$display("FAILED reset: expected mmioOpm %0d actual %0d", OPM_READY, mmioOpm);
			errors++;
		end
		checks++;
		assert (memDataOut == '0)
		else
		begin
			$display("FAILED reset: expected %h actual %h", 128'h0, memDataOut);
			errors++;
		end
		checks++;
		assert (ddrMemDataOut == '0)
		else
		begin
			$display("FAILED reset: expected ddrMemDataOut %h actual %h",
				128'h0, ddrMemDataOut);
			errors++;
		end
		checks++;
		assert (mmioOutData == '0)
		else
		begin
			$display("FAILED reset: expected mmioOutData %h actual %h", 64'h0, mmioOutData);
			errors++;
		end
		$display("%-10s %s", "reset", (errors == errorsBefore) ? "ok" : "error");
	endtask

	task automatic applyEntry(input tableEntryT t);
		int edges;
		int waitCycles;
		int errorsBefore;
		bit done;
		errorsBefore = errors;
		curName = t.name;
		@(posedge clock);
		memOpm <= t.opm;
		memAddr <= t.addr;
		memDataIn <= t.wdata;
		edges = 0;
		done = 1'b0;
		while (!done)
		begin
			@(posedge clock);
			edges++;
			@(negedge clock);
			done = (memOK == OK_OK) || (memOK == OK_FAULT);
		end
		checks++;
		assert (memOK == t.expOk)
		else
		begin
			$display("FAILED %s: expected OK code %0d actual %0d", t.name, t.expOk, memOK);
			errors++;
		end
		if (t.lat != 0)
		begin
			checks++;
			assert (edges == t.lat)
			else
			begin
				$display("FAILED %s: expected %0d edges actual %0d", t.name, t.lat, edges);
				errors++;
			end
		end
		// data only means something with OK
		if (t.expOk == OK_OK)
		begin
			checks++;
			assert (memDataOut == t.expData)
			else
			begin
				$display("FAILED %s: expected %h actual %h", t.name, t.expData, memDataOut);
				errors++;
			end
		end
		@(posedge clock);
		memOpm <= OPM_READY;
		waitCycles = 0;
		@(negedge clock);
		while ((memOK != OK_READY) && (waitCycles < 8))
		begin
			@(negedge clock);
			waitCycles++;
		end
		checks++;
		assert (memOK == OK_READY)
		else
		begin
			$display("FAILED %s release: expected OK code %0d actual %0d",
				t.name, OK_READY, memOK);
			errors++;
		end
		$display("%-10s %s", t.name, (errors == errorsBefore) ? "ok" : "error");
	endtask

	initial
	begin
		int ddrExpected;
		rstN = 1'b0;
		memOpm = OPM_READY;
		memAddr = '0;
		memDataIn = '0;
		ddrExpected = 0;
		$readmemh("romImage.hex", romRef);
		buildTable();
		tableReady = 1'b1;
		repeat (8) @(posedge clock);
		rstN <= 1'b1;
		checkIdle();
		foreach (tests[i])
		begin
			applyEntry(tests[i]);
			// line access outside the ROM window
			if ((tests[i].opm[4:3] != 2'b00) && (tests[i].opm[2:0] == 3'b111) &&
				(tests[i].addr[31:16] != 16'h0))
				ddrExpected++;
		end
		checks++;
		assert (ddrIssued == ddrExpected)
		else
		begin
			$display("FAILED ddrCount: expected %0d actual %0d", ddrExpected, ddrIssued);
			errors++;
		end
		$display("%0d tests, %0d checks, %0d errors", tests.size() + 1, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		wait (tableReady);
		#((tests.size() * 12 + 50) * 40);
		$display("timeout, test %s never got a final answer from the DUT", curName);
		$display("Testbench failed");
		$finish;
	end

endmodule
